// File: Makefile
# Verilator build and run of the write edge testbench

VERILATOR ?= verilator
TOP       ?= wr_edge_tb
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert
SIMARGS   ?= +verilator+error+limit+1000
OBJ_DIR   ?= obj_dir
FILELIST  := wr_edge.f
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP LOG FLAGS"

$(BIN): $(FILELIST) $(wildcard hw/*.sv) $(wildcard verif/*.sv)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	-$(BIN) $(SIMARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "No result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/wr_beat_replay.sv
// Write beat replay that queues control requests, rebuilds packets from the heap and frees slots
module wr_beat_replay
#(
    parameter int N_HEAP_ENTRIES = 8,
    localparam int IDX_W = $clog2(N_HEAP_ENTRIES),
    localparam int CNT_W = $clog2(N_HEAP_ENTRIES + 1)
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Control requests from the producer
    input  logic                 req_valid,
    input  wr_edge_pkg::t_addr   req_addr,
    input  wr_edge_pkg::t_cl_len req_cl_len,
    input  logic [IDX_W-1:0]     req_idx,

    // Heap read port and slot release
    output logic [IDX_W-1:0]     rd_idx,
    output wr_edge_pkg::t_cl_num rd_clnum,
    input  wr_edge_pkg::t_line   rd_data,
    output logic                 free,
    output logic [IDX_W-1:0]     free_idx,

    // Downstream beats
    input  logic                 out_alm_full,
    output logic                 out_valid,
    output logic                 out_sop,
    output wr_edge_pkg::t_cl_len out_cl_len,
    output wr_edge_pkg::t_addr   out_addr,
    output wr_edge_pkg::t_line   out_data
);
    import wr_edge_pkg::*;

    // Request FIFO, as deep as the heap so it never overflows
    t_addr            q_addr [N_HEAP_ENTRIES];
    t_cl_len          q_len  [N_HEAP_ENTRIES];
    logic [IDX_W-1:0] q_idx  [N_HEAP_ENTRIES];
    logic [IDX_W-1:0] wr_ptr;
    logic [IDX_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_cnt;

    // Packet in progress after its sop beat has gone out
    logic             busy;
    t_cl_num          beat;
    t_addr            cur_addr;
    t_cl_len          cur_len;
    logic [IDX_W-1:0] cur_idx;

    logic             start;
    logic             last_beat;

    // A packet may only begin in a cycle with no downstream back-pressure
    assign start = !busy && (q_cnt != '0) && !out_alm_full;

    // ====================
    // Beat output
    // ====================

    // The sop beat comes straight from the FIFO head; later beats follow on
    // consecutive cycles from the captured request
    always_comb
    begin
        if (busy)
        begin
            out_valid  = 1'b1;
            out_sop    = 1'b0;
            out_addr   = cur_addr;
            out_cl_len = cur_len;
            rd_idx     = cur_idx;
            rd_clnum   = beat;
        end
        else
        begin
            out_valid  = start;
            out_sop    = start;
            out_addr   = q_addr[rd_ptr];
            out_cl_len = q_len[rd_ptr];
            rd_idx     = q_idx[rd_ptr];
            rd_clnum   = '0;
        end
    end

    assign out_data  = rd_data;
    assign last_beat = out_valid && (rd_clnum == out_cl_len);

    // The slot is released with the last line read out of it
    assign free     = last_beat;
    assign free_idx = rd_idx;

    // ====================
    // Request FIFO and packet state
    // ====================

    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            q_addr[wr_ptr] <= req_addr;
            q_len[wr_ptr]  <= req_cl_len;
            q_idx[wr_ptr]  <= req_idx;
        end

        if (start)
        begin
            cur_addr <= q_addr[rd_ptr];
            cur_len  <= q_len[rd_ptr];
            cur_idx  <= q_idx[rd_ptr];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
            busy   <= 1'b0;
            beat   <= '0;
        end
        else
        begin
            if (req_valid)
            begin
                wr_ptr <= (wr_ptr == IDX_W'(N_HEAP_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (start)
            begin
                rd_ptr <= (rd_ptr == IDX_W'(N_HEAP_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end
            q_cnt <= q_cnt + CNT_W'(req_valid) - CNT_W'(start);

            // Single-beat packets finish in their start cycle
            if (start)
            begin
                busy <= (q_len[rd_ptr] != '0);
                beat <= t_cl_num'(1);
            end
            else if (busy)
            begin
                if (last_beat)
                begin
                    busy <= 1'b0;
                end
                else
                begin
                    beat <= t_cl_num'(beat + 1'b1);
                end
            end
        end
    end

endmodule

// File: hw/wr_data_heap.sv
// Write data heap holding packet lines per slot with a free list and an almost-full flag
module wr_data_heap
#(
    parameter int N_HEAP_ENTRIES = 8,
    parameter int HEAP_RESERVE = 2,
    localparam int IDX_W = $clog2(N_HEAP_ENTRIES),
    localparam int CNT_W = $clog2(N_HEAP_ENTRIES + 1)
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Line writes from the producer
    input  logic                 heap_wen,
    input  logic [IDX_W-1:0]     heap_widx,
    input  wr_edge_pkg::t_cl_num heap_wclnum,
    input  wr_edge_pkg::t_line   heap_wdata,

    // Slot allocation toward the producer
    input  logic                 alloc,
    output logic [IDX_W-1:0]     alloc_idx,

    // Read port and slot release from the consumer
    input  logic [IDX_W-1:0]     rd_idx,
    input  wr_edge_pkg::t_cl_num rd_clnum,
    output wr_edge_pkg::t_line   rd_data,
    input  logic                 free,
    input  logic [IDX_W-1:0]     free_idx,

    // Upstream flow control
    output logic                 in_alm_full
);
    import wr_edge_pkg::*;

    // Line storage, one row of MAX_BEATS lines per slot
    t_line mem [N_HEAP_ENTRIES][MAX_BEATS];

    // Circular list of free slot indices
    logic [IDX_W-1:0] free_list [N_HEAP_ENTRIES];
    // Position of the next slot to hand out
    logic [IDX_W-1:0] head;
    // Position where the next released slot is stored
    logic [IDX_W-1:0] tail;

    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] free_cnt_next;

    // ====================
    // Line storage
    // ====================

    always_ff @(posedge clk)
    begin
        if (heap_wen)
        begin
            mem[heap_widx][heap_wclnum] <= heap_wdata;
        end
    end

    // Reads are combinational so the consumer sees the line in the same
    // cycle as it sends the beat
    assign rd_data = mem[rd_idx][rd_clnum];

    // ====================
    // Free list
    // ====================

    // The head entry is the slot of the packet now arriving
    assign alloc_idx = free_list[head];

    // An allocate and a release in the same cycle leave the count alone
    always_comb
    begin
        free_cnt_next = free_cnt;
        if (alloc && !free)
        begin
            free_cnt_next = free_cnt - 1'b1;
        end
        else if (free && !alloc)
        begin
            free_cnt_next = free_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head        <= '0;
            tail        <= '0;
            free_cnt    <= CNT_W'(N_HEAP_ENTRIES);
            // Hold off the sender until the list is ready
            in_alm_full <= 1'b1;
            // Every slot starts out free, in index order
            for (int i = 0; i < N_HEAP_ENTRIES; i++)
            begin
                free_list[i] <= IDX_W'(i);
            end
        end
        else
        begin
            if (alloc)
            begin
                head <= (head == IDX_W'(N_HEAP_ENTRIES - 1)) ? '0 : head + 1'b1;
            end

            // Released slots go to the back of the list
            if (free)
            begin
                free_list[tail] <= free_idx;
                tail <= (tail == IDX_W'(N_HEAP_ENTRIES - 1)) ? '0 : tail + 1'b1;
            end

            free_cnt <= free_cnt_next;

            // The reserve covers the packet that may still be arriving when the
            // flag rises, since one packet only ever needs one slot
            in_alm_full <= (free_cnt_next <= CNT_W'(HEAP_RESERVE));
        end
    end

endmodule

// File: hw/wr_edge_pkg.sv
// Shared types and fixed protocol constants of the write edge data path
package wr_edge_pkg;

    // ====================
    // Protocol constants
    // ====================

    // Width of one data line in bits
    localparam int LINE_W = 64;

    // Width of a line address in bits
    localparam int ADDR_W = 32;

    // Largest number of beats in one write packet
    localparam int MAX_BEATS = 4;

    // Bits needed to number the beats of the longest packet
    localparam int CL_W = $clog2(MAX_BEATS);

    // ====================
    // Payload types
    // ====================

    // One data line as it travels with a write beat
    typedef logic [LINE_W-1:0] t_line;

    // Line address of a write packet
    // A packet of n+1 beats is aligned to a multiple of n+1 lines
    typedef logic [ADDR_W-1:0] t_addr;

    // ====================
    // Packet framing types
    // ====================

    // Packet length minus one, so zero means a single-beat packet
    typedef logic [CL_W-1:0] t_cl_len;

    // Beat number inside a packet, counting from zero at the sop beat
    // The last beat is the one whose number equals the packet's t_cl_len
    typedef logic [CL_W-1:0] t_cl_num;

    // Beat numbers and lengths are compared directly in the producer and
    // the consumer, so both types must keep the same width
    // Changing MAX_BEATS changes both of them together

endpackage

// File: hw/wr_edge_top.sv
// Write edge top level joining the packet producer, the data heap and the beat replay
module wr_edge_top
#(
    parameter int N_HEAP_ENTRIES = 8,
    parameter int HEAP_RESERVE = 2,
    localparam int IDX_W = $clog2(N_HEAP_ENTRIES)
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Accelerator side
    input  logic                 in_valid,
    input  logic                 in_sop,
    input  wr_edge_pkg::t_cl_len in_cl_len,
    input  wr_edge_pkg::t_addr   in_addr,
    input  wr_edge_pkg::t_line   in_data,
    output logic                 in_alm_full,

    // Memory side
    input  logic                 out_alm_full,
    output logic                 out_valid,
    output logic                 out_sop,
    output wr_edge_pkg::t_cl_len out_cl_len,
    output wr_edge_pkg::t_addr   out_addr,
    output wr_edge_pkg::t_line   out_data
);
    import wr_edge_pkg::*;

    // Heap write and allocation
    logic             heap_wen;
    logic [IDX_W-1:0] heap_widx;
    t_cl_num          heap_wclnum;
    t_line            heap_wdata;
    logic             alloc;
    logic [IDX_W-1:0] alloc_idx;

    // Control requests, one per stored packet
    logic             req_valid;
    t_addr            req_addr;
    t_cl_len          req_cl_len;
    logic [IDX_W-1:0] req_idx;

    // Heap read and release
    logic [IDX_W-1:0] rd_idx;
    t_cl_num          rd_clnum;
    t_line            rd_data;
    logic             free;
    logic [IDX_W-1:0] free_idx;

    wr_packet_canon #(.N_HEAP_ENTRIES(N_HEAP_ENTRIES)) wr_packet_canon_i (.*);

    wr_data_heap #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES),
        .HEAP_RESERVE(HEAP_RESERVE)
    ) wr_data_heap_i (.*);

    wr_beat_replay #(.N_HEAP_ENTRIES(N_HEAP_ENTRIES)) wr_beat_replay_i (.*);

endmodule

// File: hw/wr_packet_canon.sv
// Write packet producer that restores sop headers, fills the heap and issues one request per packet
module wr_packet_canon
#(
    parameter int N_HEAP_ENTRIES = 8,
    localparam int IDX_W = $clog2(N_HEAP_ENTRIES)
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Beats from the accelerator, every valid cycle is one accepted beat
    input  logic                 in_valid,
    input  logic                 in_sop,
    input  wr_edge_pkg::t_cl_len in_cl_len,
    input  wr_edge_pkg::t_addr   in_addr,
    input  wr_edge_pkg::t_line   in_data,

    // Slot that the heap keeps ready for the packet now arriving
    input  logic [IDX_W-1:0]     alloc_idx,

    // Heap write port, driven in the same cycle as the beat
    output logic                 heap_wen,
    output logic [IDX_W-1:0]     heap_widx,
    output wr_edge_pkg::t_cl_num heap_wclnum,
    output wr_edge_pkg::t_line   heap_wdata,
    output logic                 alloc,

    // One control request per packet toward the consumer
    output logic                 req_valid,
    output wr_edge_pkg::t_addr   req_addr,
    output wr_edge_pkg::t_cl_len req_cl_len,
    output logic [IDX_W-1:0]     req_idx
);
    import wr_edge_pkg::*;

    // High once a multi-beat packet has started and until its last beat
    logic    pkt_active;
    // Number that the next beat of the open packet will carry
    t_cl_num beat_num;

    // Header fields captured from the sop beat
    t_addr   sop_addr;
    t_cl_len sop_len;

    // Canonical view of the beat in the current cycle
    t_addr   canon_addr;
    t_cl_len canon_len;
    t_cl_num canon_num;
    logic    last_beat;

    // ====================
    // Canonical header
    // ====================

    // Later beats may carry garbage in the length and address fields, so only
    // the sop beat is trusted and the others reuse its captured header
    always_comb
    begin
        if (in_sop)
        begin
            canon_addr = in_addr;
            canon_len  = in_cl_len;
        end
        else
        begin
            canon_addr = sop_addr;
            canon_len  = sop_len;
        end

        // The beat count restarts whenever no packet is open
        canon_num = pkt_active ? beat_num : '0;
    end

    assign last_beat = in_valid && (canon_num == canon_len);

    // Data goes to the current slot at the beat's own line position
    assign heap_wen    = in_valid;
    assign heap_widx   = alloc_idx;
    assign heap_wclnum = canon_num;
    assign heap_wdata  = in_data;

    // The slot is claimed only once the whole packet is stored
    assign alloc = last_beat;

    // ====================
    // Beat tracking
    // ====================

    // Header capture and request payload hold no control state
    always_ff @(posedge clk)
    begin
        if (in_valid && in_sop)
        begin
            sop_addr <= in_addr;
            sop_len  <= in_cl_len;
        end

        // The request names the slot that this last beat just filled
        if (last_beat)
        begin
            req_addr   <= canon_addr;
            req_cl_len <= canon_len;
            req_idx    <= alloc_idx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pkt_active <= 1'b0;
            beat_num   <= '0;
            req_valid  <= 1'b0;
        end
        else
        begin
            // The request leaves one cycle after the last beat
            req_valid <= last_beat;

            if (in_valid)
            begin
                pkt_active <= !last_beat;
                beat_num   <= t_cl_num'(canon_num + 1'b1);
            end
        end
    end

endmodule

// File: verif/wr_edge_assert.sv
// Packet format assertions on the beats that reach the write packet producer
module wr_edge_assert
(
    input logic                 clk,
    input logic                 reset,
    input logic                 in_valid,
    input logic                 in_sop,
    input wr_edge_pkg::t_addr   canon_addr,
    input wr_edge_pkg::t_cl_len canon_len,
    input logic                 pkt_active
);
    import wr_edge_pkg::*;

    // Number of assertion failures so far
    int fail_count = 0;

    // A sop beat never lands inside an open packet
    sop_outside_packet: assert property (@(posedge clk) disable iff (reset)
        in_valid && in_sop |-> !pkt_active)
    else
    begin
        $error("sop beat arrived inside an open packet");
        fail_count++;
    end

    // A beat without sop only continues an open packet
    body_inside_packet: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_sop |-> pkt_active)
    else
    begin
        $error("beat without sop arrived outside a packet");
        fail_count++;
    end

    // Every beat carries the header of its sop beat
    // Its line address is a multiple of the packet's beat count
    sop_addr_aligned: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> (canon_addr % (t_addr'(canon_len) + t_addr'(1))) == '0)
    else
    begin
        $error("sop address 0x%0h not aligned to length %0d", canon_addr, canon_len);
        fail_count++;
    end

endmodule

// File: verif/wr_edge_checker.sv
// Output checker that compares write beats against the testbench model and counts errors
module wr_edge_checker
#(
    parameter int N_HEAP_ENTRIES = 8
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  logic                 in_sop,
    input  logic                 in_alm_full,
    input  logic                 out_alm_full,
    input  logic                 out_valid,
    input  logic                 out_sop,
    input  wr_edge_pkg::t_cl_len out_cl_len,
    input  wr_edge_pkg::t_addr   out_addr,
    input  wr_edge_pkg::t_line   out_data,
    output int                   value_errors,
    output int                   other_errors,
    output int                   beats_out
);
    import wr_edge_pkg::*;

    // One expected output beat in canonical form
    typedef struct packed {
        logic    last;
        logic    sop;
        t_cl_len len;
        t_addr   addr;
        t_line   data;
    } t_exp_beat;

    t_exp_beat exp_q [$];
    t_exp_beat exp_beat;
    int   value_cnt = 0;
    int   other_cnt = 0;
    int   out_cnt = 0;
    // Packets started at the input and not yet fully replayed
    int   pending = 0;
    logic reset_d = 1'b0;
    logic in_pkt = 1'b0;

    assign value_errors = value_cnt;
    assign other_errors = other_cnt;
    assign beats_out    = out_cnt;

    // Called by the sender for every beat it drives
    task automatic expect_beat(input logic sop, input logic last, input t_cl_len len,
                               input t_addr addr, input t_line data);
        exp_q.push_back('{last: last, sop: sop, len: len, addr: addr, data: data});
    endtask

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp)
        begin
            value_cnt++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    always @(posedge clk)
    begin
        reset_d <= reset;
        // Sender held off and output idle during reset and on the cycle after it
        if (reset_d)
        begin
            compare_field("in_alm_full", 64'(in_alm_full), 64'd1);
            compare_field("out_valid", 64'(out_valid), 64'd0);
        end
        if (!reset)
        begin
            if (in_valid && in_sop)
            begin
                pending++;
            end
            if (out_valid && out_sop && out_alm_full)
            begin
                other_cnt++;
                $display("Output packet started while out_alm_full was high");
            end
            if (in_pkt && !out_valid)
            begin
                other_cnt++;
                $display("Output packet has a gap between its beats");
            end
            if (out_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    other_cnt++;
                    $display("Output beat arrived with no expected beat left");
                end
                else
                begin
                    exp_beat = exp_q.pop_front();
                    compare_field("out_sop", 64'(out_sop), 64'(exp_beat.sop));
                    compare_field("out_cl_len", 64'(out_cl_len), 64'(exp_beat.len));
                    compare_field("out_addr", 64'(out_addr), 64'(exp_beat.addr));
                    compare_field("out_data", out_data, exp_beat.data);
                    out_cnt++;
                    in_pkt <= !exp_beat.last;
                    if (exp_beat.last)
                    begin
                        pending--;
                    end
                end
            end
            // The upstream flag has to stop the sender before the heap runs out
            if (pending > N_HEAP_ENTRIES)
            begin
                other_cnt++;
                $display("%0d packets waiting, more than the %0d heap slots",
                         pending, N_HEAP_ENTRIES);
            end
        end
    end

endmodule

// File: verif/wr_edge_tb.sv
// Testbench for the write edge with seeded random packets, downstream back-pressure and a beat model
module wr_edge_tb;
    import wr_edge_pkg::*;

    localparam int NUM_PACKETS    = 200;
    localparam int CLK_HALF       = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int N_HEAP_ENTRIES = 8;
    // Budget of 20 cycles per packet with margin for reset and the long stalls
    localparam int MAX_CYCLES     = NUM_PACKETS * 20 + 500;

    logic    clk = 1'b0;
    logic    reset;
    logic    in_valid;
    logic    in_sop;
    t_cl_len in_cl_len;
    t_addr   in_addr;
    t_line   in_data;
    logic    in_alm_full;
    logic    out_alm_full;
    logic    out_valid;
    logic    out_sop;
    t_cl_len out_cl_len;
    t_addr   out_addr;
    t_line   out_data;

    int seed = 32'h013c_3d8d;
    int cycles = 0;
    int beats_sent = 0;
    int value_errors;
    int other_errors;
    int beats_out;
    int assert_fails;

    always #CLK_HALF clk = ~clk;

    wr_edge_top #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES),
        .HEAP_RESERVE(2)
    ) wr_edge_top_i (.*);

    wr_edge_checker #(.N_HEAP_ENTRIES(N_HEAP_ENTRIES)) check_i (.*);

    // The producer holds the open packet state and the canonical header
    bind wr_packet_canon wr_edge_assert wr_edge_assert_i (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_sop(in_sop),
        .canon_addr(canon_addr),
        .canon_len(canon_len),
        .pkt_active(pkt_active)
    );

    // ====================
    // Stimulus helpers
    // ====================

    // One cycle without a beat while the header fields carry garbage
    task automatic idle_cycle();
        in_valid  = 1'b0;
        in_sop    = 1'b0;
        in_cl_len = t_cl_len'($random(seed));
        in_addr   = $random(seed);
        @(posedge clk);
        #1;
    endtask

    // Zero to three idle cycles
    task automatic random_gap();
        logic [31:0] r;
        r = $random(seed);
        repeat (r[1:0]) idle_cycle();
    endtask

    task automatic send_packet();
        logic [31:0] r;
        t_cl_len     len;
        t_addr       addr;
        t_line       data;
        int          b;
        r    = $random(seed);
        len  = r[1:0];
        addr = $random(seed);
        // Align the line address to a multiple of the packet's beat count
        addr = addr - (addr % (t_addr'(len) + t_addr'(1)));
        random_gap();
        // A new packet may only start while the heap still has room
        while (in_alm_full)
        begin
            idle_cycle();
        end
        for (b = 0; b <= int'(len); b++)
        begin
            if (b > 0)
            begin
                random_gap();
            end
            data      = {$random(seed), $random(seed)};
            in_valid  = 1'b1;
            in_sop    = (b == 0);
            in_data   = data;
            // Only the sop beat carries a real header
            in_cl_len = (b == 0) ? len : t_cl_len'($random(seed));
            in_addr   = (b == 0) ? addr : t_addr'($random(seed));
            // The model always holds the canonical header of the packet
            check_i.expect_beat(b == 0, b == int'(len), len, addr, data);
            beats_sent++;
            @(posedge clk);
            #1;
        end
    endtask

    // ====================
    // Downstream back-pressure
    // ====================

    // The receiver raises its almost-full flag at random and sometimes holds it for 40 cycles
    initial
    begin
        int          hold;
        logic [31:0] r;
        out_alm_full = 1'b0;
        @(negedge reset);
        // One long stall right away makes the heap fill up early in the run
        hold = 40;
        forever
        begin
            @(posedge clk);
            #2;
            r = $random(seed);
            if (hold > 0)
            begin
                out_alm_full = 1'b1;
                hold--;
            end
            else if (r[6:0] == 7'd0)
            begin
                out_alm_full = 1'b1;
                hold = 39;
            end
            else
            begin
                out_alm_full = (r[9:8] == 2'd0);
            end
        end
    end

    // Cycle counter that stops a run that hangs
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d of %0d beats out",
                     cycles, beats_out, beats_sent);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial
    begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_sop    = 1'b0;
        in_cl_len = '0;
        in_addr   = '0;
        in_data   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int p = 0; p < NUM_PACKETS; p++)
        begin
            send_packet();
        end
        in_valid = 1'b0;
        in_sop   = 1'b0;
        // Every beat sent has to come back out before the report
        while (beats_out != beats_sent)
        begin
            @(posedge clk);
        end
        // A few quiet cycles catch any stray beat after the last one
        repeat (10) @(posedge clk);
        #1;
        assert_fails = wr_edge_top_i.wr_packet_canon_i.wr_edge_assert_i.fail_count;
        $display("Error counts: %0d value, %0d protocol, %0d assertion",
                 value_errors, other_errors, assert_fails);
        if (value_errors + other_errors + assert_fails == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: wr_edge.f
hw/wr_edge_pkg.sv
hw/wr_packet_canon.sv
hw/wr_data_heap.sv
hw/wr_beat_replay.sv
hw/wr_edge_top.sv
verif/wr_edge_assert.sv
verif/wr_edge_checker.sv
verif/wr_edge_tb.sv
